/* logic/tag_defines.svh */
// Global parameters for the tag board computer
// Bus widths, serial timing, display location and protocol bytes

`ifndef TAG_DEFINES_SVH
`define TAG_DEFINES_SVH

////////////////////////////////////////////////////////////
// Memory bus
////////////////////////////////////////////////////////////

// One byte per word
`define TAG_DATA_W 8
`define TAG_ADDR_W 8
`define TAG_MEM_DEPTH 256

////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////

// Clock cycles per serial bit, short for simulation
`define TAG_BAUD_DIV 8
// Cycles between display reads
`define TAG_REFRESH_CYCLES 64

////////////////////////////////////////////////////////////
// Display and protocol
////////////////////////////////////////////////////////////

// Word whose low nibble shows on HEX0
`define TAG_HEX_ADDR 8'hF0
// Answer to a write command, 'K'
`define TAG_ACK_BYTE 8'h4B

`endif

/* logic/tag_bus_pkg.sv */
// Types of the shared memory bus
// Master indices and arbiter states
`default_nettype none

package tag_bus_pkg;

    // Bus masters in arbiter port order
    typedef enum logic [0:0] {
        MASTER_UART = 1'b0,
        MASTER_HEX  = 1'b1
    } master_e;

    // Arbiter state
    // ARB_READ holds off new grants while rvalid returns
    typedef enum logic [0:0] {
        ARB_IDLE = 1'b0,
        ARB_READ = 1'b1
    } arb_state_e;

endpackage: tag_bus_pkg

`default_nettype wire

/* logic/tag_uart_pkg.sv */
// Types of the serial command protocol
// Opcodes, command bridge states, serializer states
`default_nettype none

package tag_uart_pkg;

    // Opcode bytes, ASCII 'W' and 'R'
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h57,
        CMD_READ  = 8'h52
    } cmd_op_e;

    // Command bridge sequence
    typedef enum logic [2:0] {
        BR_IDLE,
        BR_ADDR,
        BR_DATA,
        BR_REQ,
        BR_WAIT,
        BR_SEND
    } bridge_state_e;

    // Shared by receiver and transmitter
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_START,
        SER_DATA,
        SER_STOP
    } serial_state_e;

endpackage: tag_uart_pkg

`default_nettype wire

/* logic/mem_bus_if.sv */
// Request and read-back path of one bus master
// Request fields stay stable from req until gnt
`default_nettype none
`include "tag_defines.svh"

interface mem_bus_if;

    // Master side request
    logic req;
    logic we;
    logic [`TAG_ADDR_W-1:0] addr;
    logic [`TAG_DATA_W-1:0] wdata;

    // Arbiter side answer
    logic gnt;
    logic [`TAG_DATA_W-1:0] rdata;
    // One cycle after a read grant
    logic rvalid;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport slave (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface: mem_bus_if

`default_nettype wire

/* logic/word_ram.sv */
// On-chip word memory standing in for the SDRAM
// Registered read port, one cycle latency
`default_nettype none
`include "tag_defines.svh"

module word_ram (
    input  logic CLOCK_50,
    input  logic rst_n,
    input  logic en,
    input  logic we,
    input  logic [`TAG_ADDR_W-1:0] addr,
    input  logic [`TAG_DATA_W-1:0] wdata,
    output logic [`TAG_DATA_W-1:0] rdata
);

    logic [`TAG_DATA_W-1:0] mem [`TAG_MEM_DEPTH];

    // Reset zeroes the array, unwritten words read back as 0
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TAG_MEM_DEPTH; i++)
                mem[i] <= '0;
            rdata <= '0;
        end else if (en) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule: word_ram

`default_nettype wire

/* logic/bus_arbiter.sv */
// Round-robin arbiter for two bus masters in front of the word memory
// Grants in the request cycle, routes read data to its owner only
`default_nettype none
`include "tag_defines.svh"

module bus_arbiter (
    input  logic CLOCK_50,
    input  logic rst_n,
    mem_bus_if.slave m_uart,
    mem_bus_if.slave m_hex,
    output logic mem_en,
    output logic mem_we,
    output logic [`TAG_ADDR_W-1:0] mem_addr,
    output logic [`TAG_DATA_W-1:0] mem_wdata,
    input  logic [`TAG_DATA_W-1:0] mem_rdata
);

    tag_bus_pkg::arb_state_e state;
    tag_bus_pkg::master_e last_served;
    tag_bus_pkg::master_e read_owner;
    tag_bus_pkg::master_e pick;
    logic grant;

    // Tie goes to the master not served last
    always_comb begin
        if (m_uart.req && m_hex.req)
            pick = (last_served == tag_bus_pkg::MASTER_UART) ?
                   tag_bus_pkg::MASTER_HEX : tag_bus_pkg::MASTER_UART;
        else if (m_hex.req)
            pick = tag_bus_pkg::MASTER_HEX;
        else
            pick = tag_bus_pkg::MASTER_UART;
    end

    // No grant while a read is returning
    assign grant = (m_uart.req || m_hex.req) && (state == tag_bus_pkg::ARB_IDLE);

    assign m_uart.gnt = grant && (pick == tag_bus_pkg::MASTER_UART);
    assign m_hex.gnt  = grant && (pick == tag_bus_pkg::MASTER_HEX);

    // Winner's fields to the memory
    assign mem_en    = grant;
    assign mem_we    = (pick == tag_bus_pkg::MASTER_HEX) ? m_hex.we : m_uart.we;
    assign mem_addr  = (pick == tag_bus_pkg::MASTER_HEX) ? m_hex.addr : m_uart.addr;
    assign mem_wdata = (pick == tag_bus_pkg::MASTER_HEX) ? m_hex.wdata : m_uart.wdata;

    // Read return, the other master sees nothing
    assign m_uart.rvalid = (state == tag_bus_pkg::ARB_READ) &&
                           (read_owner == tag_bus_pkg::MASTER_UART);
    assign m_hex.rvalid  = (state == tag_bus_pkg::ARB_READ) &&
                           (read_owner == tag_bus_pkg::MASTER_HEX);
    assign m_uart.rdata  = (read_owner == tag_bus_pkg::MASTER_UART) ? mem_rdata : '0;
    assign m_hex.rdata   = (read_owner == tag_bus_pkg::MASTER_HEX) ? mem_rdata : '0;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= tag_bus_pkg::ARB_IDLE;
            // Bridge wins the first tie
            last_served <= tag_bus_pkg::MASTER_HEX;
            read_owner  <= tag_bus_pkg::MASTER_UART;
        end else if (state == tag_bus_pkg::ARB_READ) begin
            state <= tag_bus_pkg::ARB_IDLE;
        end else if (grant) begin
            last_served <= pick;
            if (!mem_we) begin
                read_owner <= pick;
                state      <= tag_bus_pkg::ARB_READ;
            end
        end
    end

endmodule: bus_arbiter

`default_nettype wire

/* logic/hex_refresh.sv */
// Periodic display reader
// Fetches the display word over the bus and drives HEX0 from its low nibble
`default_nettype none
`include "tag_defines.svh"

module hex_refresh (
    input  logic CLOCK_50,
    input  logic rst_n,
    mem_bus_if.master bus,
    output logic [6:0] hex0
);

    localparam int CNT_W = $clog2(`TAG_REFRESH_CYCLES);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`TAG_REFRESH_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    // Active-low segments, bit 6 is g
    function automatic logic [6:0] seg_decode(input logic [3:0] nib);
        case (nib)
            4'h0: seg_decode = 7'b1000000;
            4'h1: seg_decode = 7'b1111001;
            4'h2: seg_decode = 7'b0100100;
            4'h3: seg_decode = 7'b0110000;
            4'h4: seg_decode = 7'b0011001;
            4'h5: seg_decode = 7'b0010010;
            4'h6: seg_decode = 7'b0000010;
            4'h7: seg_decode = 7'b1111000;
            4'h8: seg_decode = 7'b0000000;
            4'h9: seg_decode = 7'b0010000;
            4'hA: seg_decode = 7'b0001000;
            4'hB: seg_decode = 7'b0000011;
            4'hC: seg_decode = 7'b1000110;
            4'hD: seg_decode = 7'b0100001;
            4'hE: seg_decode = 7'b0000110;
            default: seg_decode = 7'b0001110;
        endcase
    endfunction

    // Read-only master at a fixed address
    assign bus.we    = 1'b0;
    assign bus.addr  = `TAG_HEX_ADDR;
    assign bus.wdata = '0;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= RELOAD;
            bus.req <= 1'b0;
            // Blank until the first read lands
            hex0    <= 7'b1111111;
        end else begin
            cnt <= (cnt == '0) ? RELOAD : cnt - 1'b1;
            // Request held until the arbiter grants it
            if (bus.req && bus.gnt)
                bus.req <= 1'b0;
            else if (cnt == '0)
                bus.req <= 1'b1;
            if (bus.rvalid)
                hex0 <= seg_decode(bus.rdata[3:0]);
        end
    end

endmodule: hex_refresh

`default_nettype wire

/* logic/uart_cmd_bridge.sv */
// Serial command bridge to the memory bus
// Receives W/R commands, issues one bus access, answers on the TX line
`default_nettype none
`include "tag_defines.svh"

module uart_cmd_bridge (
    input  logic CLOCK_50,
    input  logic rst_n,
    input  logic uart_rxd,
    output logic uart_txd,
    mem_bus_if.master bus
);

    localparam int BAUD_W = $clog2(`TAG_BAUD_DIV);
    // Last cycle of a bit, and the cycle at mid start bit
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`TAG_BAUD_DIV - 1);
    localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(`TAG_BAUD_DIV / 2 - 1);

    logic rx_meta;
    logic rx_sync;
    tag_uart_pkg::serial_state_e rx_state;
    logic [BAUD_W-1:0] rx_cnt;
    logic [2:0] rx_bit;
    logic [7:0] rx_shift;
    logic rx_valid;

    tag_uart_pkg::bridge_state_e br_state;
    tag_uart_pkg::cmd_op_e op;
    logic [`TAG_ADDR_W-1:0] addr_q;
    logic [`TAG_DATA_W-1:0] wdata_q;
    logic [7:0] tx_byte;
    logic tx_go;

    tag_uart_pkg::serial_state_e tx_state;
    logic [BAUD_W-1:0] tx_cnt;
    logic [2:0] tx_bit;
    logic [7:0] tx_shift;
    logic tx_done;

    ////////////////////////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////////////////////////

    // Two flop synchronizer, line idles high
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rxd;
            rx_sync <= rx_meta;
        end
    end

    // Mid-bit sampling, LSB first
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= tag_uart_pkg::SER_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_shift <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (rx_state)
                tag_uart_pkg::SER_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync)
                        rx_state <= tag_uart_pkg::SER_START;
                end
                tag_uart_pkg::SER_START: begin
                    if (rx_cnt == BAUD_HALF) begin
                        rx_cnt <= '0;
                        rx_bit <= '0;
                        // Glitch on the line, not a real start bit
                        rx_state <= rx_sync ? tag_uart_pkg::SER_IDLE : tag_uart_pkg::SER_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                tag_uart_pkg::SER_DATA: begin
                    if (rx_cnt == BAUD_LAST) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7)
                            rx_state <= tag_uart_pkg::SER_STOP;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    // Low stop bit means framing error, byte dropped
                    if (rx_cnt == BAUD_LAST) begin
                        rx_valid <= rx_sync;
                        rx_state <= tag_uart_pkg::SER_IDLE;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Command decoder and bus master
    ////////////////////////////////////////////////////////////

    // Request held for the whole BR_REQ state
    assign bus.req   = (br_state == tag_uart_pkg::BR_REQ);
    assign bus.we    = (op == tag_uart_pkg::CMD_WRITE);
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            br_state <= tag_uart_pkg::BR_IDLE;
            op       <= tag_uart_pkg::CMD_READ;
            addr_q   <= '0;
            wdata_q  <= '0;
            tx_byte  <= '0;
            tx_go    <= 1'b0;
        end else begin
            tx_go <= 1'b0;
            case (br_state)
                tag_uart_pkg::BR_IDLE: begin
                    // Unknown opcodes fall through silently
                    if (rx_valid && (rx_shift == tag_uart_pkg::CMD_WRITE ||
                                     rx_shift == tag_uart_pkg::CMD_READ)) begin
                        op       <= tag_uart_pkg::cmd_op_e'(rx_shift);
                        br_state <= tag_uart_pkg::BR_ADDR;
                    end
                end
                tag_uart_pkg::BR_ADDR: begin
                    if (rx_valid) begin
                        addr_q <= rx_shift;
                        if (op == tag_uart_pkg::CMD_WRITE)
                            br_state <= tag_uart_pkg::BR_DATA;
                        else
                            br_state <= tag_uart_pkg::BR_REQ;
                    end
                end
                tag_uart_pkg::BR_DATA: begin
                    if (rx_valid) begin
                        wdata_q  <= rx_shift;
                        br_state <= tag_uart_pkg::BR_REQ;
                    end
                end
                tag_uart_pkg::BR_REQ: begin
                    if (bus.gnt) begin
                        if (op == tag_uart_pkg::CMD_WRITE) begin
                            // Write done at grant, ack right away
                            tx_byte  <= `TAG_ACK_BYTE;
                            tx_go    <= 1'b1;
                            br_state <= tag_uart_pkg::BR_SEND;
                        end else begin
                            br_state <= tag_uart_pkg::BR_WAIT;
                        end
                    end
                end
                tag_uart_pkg::BR_WAIT: begin
                    if (bus.rvalid) begin
                        tx_byte  <= bus.rdata;
                        tx_go    <= 1'b1;
                        br_state <= tag_uart_pkg::BR_SEND;
                    end
                end
                default: begin
                    // Incoming bytes ignored until the answer is out
                    if (tx_done)
                        br_state <= tag_uart_pkg::BR_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////////////////////////

    // Start, 8 data bits LSB first, stop
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= tag_uart_pkg::SER_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_shift <= '0;
            tx_done  <= 1'b0;
            uart_txd <= 1'b1;
        end else begin
            tx_done <= 1'b0;
            case (tx_state)
                tag_uart_pkg::SER_IDLE: begin
                    uart_txd <= 1'b1;
                    tx_cnt   <= '0;
                    if (tx_go) begin
                        tx_shift <= tx_byte;
                        uart_txd <= 1'b0;
                        tx_state <= tag_uart_pkg::SER_START;
                    end
                end
                tag_uart_pkg::SER_START: begin
                    if (tx_cnt == BAUD_LAST) begin
                        tx_cnt   <= '0;
                        tx_bit   <= '0;
                        uart_txd <= tx_shift[0];
                        tx_state <= tag_uart_pkg::SER_DATA;
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                tag_uart_pkg::SER_DATA: begin
                    if (tx_cnt == BAUD_LAST) begin
                        tx_cnt <= '0;
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            uart_txd <= 1'b1;
                            tx_state <= tag_uart_pkg::SER_STOP;
                        end else begin
                            uart_txd <= tx_shift[1];
                            tx_shift <= tx_shift >> 1;
                        end
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                default: begin
                    // Full stop bit before the bridge takes a new command
                    if (tx_cnt == BAUD_LAST) begin
                        tx_done  <= 1'b1;
                        tx_state <= tag_uart_pkg::SER_IDLE;
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule: uart_cmd_bridge

`default_nettype wire

/* logic/tag_computer.sv */
// Top level of the tag board computer
// Serial command bridge and display refresher sharing one word memory
`default_nettype none
`include "tag_defines.svh"

module tag_computer (
    // 50 MHz board clock
    input  logic CLOCK_50,
    input  logic rst_n,
    // Bluetooth UART on the GPIO header
    input  logic uart_rxd,
    output logic uart_txd,
    // Rightmost seven-segment display
    output logic [6:0] hex0
);

    logic mem_en;
    logic mem_we;
    logic [`TAG_ADDR_W-1:0] mem_addr;
    logic [`TAG_DATA_W-1:0] mem_wdata;
    logic [`TAG_DATA_W-1:0] mem_rdata;

    ////////////////////////////////////////////////////////////
    // Bus masters
    ////////////////////////////////////////////////////////////

    mem_bus_if uart_bus ();
    mem_bus_if hex_bus ();

    // Stands in for the soft processor, MASTER_UART
    uart_cmd_bridge bridge (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .bus      (uart_bus.master)
    );

    // Display reader, MASTER_HEX
    hex_refresh refresher (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .bus      (hex_bus.master),
        .hex0     (hex0)
    );

    ////////////////////////////////////////////////////////////
    // Arbiter and memory
    ////////////////////////////////////////////////////////////

    bus_arbiter arbiter (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .m_uart    (uart_bus.slave),
        .m_hex     (hex_bus.slave),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    word_ram ram (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .en       (mem_en),
        .we       (mem_we),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .rdata    (mem_rdata)
    );

endmodule: tag_computer

`default_nettype wire

/* tests/tag_computer_tb.sv */
// Testbench for the tag board computer
// Plays golden-file commands over serial, checks answers and HEX0
`default_nettype none
`include "tag_defines.svh"

module tag_computer_tb;

    localparam string GOLDEN_FILE = "tests/tag_golden.txt";
    localparam int BIT_CYCLES = `TAG_BAUD_DIV;
    // Budget per golden line or burst access
    localparam int LINE_CYCLES = 80 * BIT_CYCLES;
    // Answer must start within this many cycles
    localparam int ANSWER_CYCLES = 40 * BIT_CYCLES;
    localparam int SILENCE_CYCLES = 30 * BIT_CYCLES;

    // Test kinds, first column of the golden file
    localparam int K_RESET = 0;
    localparam int K_WRITE = 1;
    localparam int K_READ = 2;
    localparam int K_BAD_STOP = 3;
    localparam int K_UNKNOWN = 4;
    localparam int K_DISPLAY = 5;
    localparam int K_BURST = 6;

    // Active-low gfedcba patterns for 0 to F
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic clk;
    logic rst_n;
    logic uart_rxd;
    logic uart_txd;
    logic [6:0] hex0;

    // Words written so far as the DUT should hold them
    logic [7:0] shadow [`TAG_MEM_DEPTH];
    int seed;
    int error_count;
    int pass_count;
    int fail_count;
    int watch_cycles;

    tag_computer tag_computer_inst (
        .CLOCK_50 (clk),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .hex0     (hex0)
    );

    always #2 clk = ~clk;

    // Watchdog armed once the test list is sized
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the test sequence did not finish", watch_cycles);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Serial line tasks
    ////////////////////////////////////////////////////////////

    // Start bit, 8 data bits LSB first, stop bit as given
    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        logic [9:0] frame;
        int i;
        frame = {stop_bit, b, 1'b0};
        @(negedge clk);
        for (i = 0; i < 10; i++) begin
            uart_rxd = frame[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        uart_rxd = 1'b1;
    endtask

    // Wait for a start bit, then sample mid-bit
    task automatic receive_byte(input int limit, output logic got, output logic [7:0] b);
        int waited;
        int i;
        waited = 0;
        got = 1'b0;
        b = '0;
        while (!got && waited < limit) begin
            @(negedge clk);
            if (uart_txd == 1'b0)
                got = 1'b1;
            else
                waited++;
        end
        if (got) begin
            repeat (BIT_CYCLES / 2) @(negedge clk);
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                b[i] = uart_txd;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            if (uart_txd != 1'b1) begin
                $display("Error at %0t: answer byte 0x%02h has a low stop bit", $time, b);
                error_count++;
            end
            repeat (BIT_CYCLES / 2) @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Command level checks
    ////////////////////////////////////////////////////////////

    task automatic do_write(input logic [7:0] op, input logic [7:0] addr,
                            input logic [7:0] data);
        logic got;
        logic [7:0] answer;
        send_byte(op, 1'b1);
        send_byte(addr, 1'b1);
        send_byte(data, 1'b1);
        receive_byte(ANSWER_CYCLES, got, answer);
        if (!got) begin
            $display("Error at %0t: no ack for write of 0x%02h to 0x%02h", $time, data, addr);
            error_count++;
        end else if (answer != `TAG_ACK_BYTE) begin
            $display("Error at %0t: write ack 0x%02h, expected 0x%02h",
                     $time, answer, `TAG_ACK_BYTE);
            error_count++;
        end
        shadow[addr] = data;
        repeat (2 * BIT_CYCLES) @(negedge clk);
    endtask

    task automatic do_read(input logic [7:0] op, input logic [7:0] addr,
                           input logic [7:0] expected);
        logic got;
        logic [7:0] answer;
        send_byte(op, 1'b1);
        send_byte(addr, 1'b1);
        receive_byte(ANSWER_CYCLES, got, answer);
        if (!got) begin
            $display("Error at %0t: no answer to read of 0x%02h", $time, addr);
            error_count++;
        end else if (answer != expected) begin
            $display("Error at %0t: read of 0x%02h returned 0x%02h, expected 0x%02h",
                     $time, addr, answer, expected);
            error_count++;
        end
        repeat (2 * BIT_CYCLES) @(negedge clk);
    endtask

    // Nothing may come back for a dropped byte
    task automatic expect_silence(input logic [7:0] b, input logic stop_bit);
        logic got;
        logic [7:0] answer;
        send_byte(b, stop_bit);
        receive_byte(SILENCE_CYCLES, got, answer);
        if (got) begin
            $display("Error at %0t: answer 0x%02h to dropped byte 0x%02h", $time, answer, b);
            error_count++;
        end
    endtask

    // Pattern must appear within two refresh periods
    task automatic check_display(input logic [6:0] expected);
        int waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < 2 * `TAG_REFRESH_CYCLES) begin
            @(negedge clk);
            if (hex0 == expected)
                seen = 1'b1;
            else
                waited++;
        end
        if (!seen) begin
            $display("Error at %0t: hex0 is 0x%02h, expected 0x%02h", $time, hex0, expected);
            error_count++;
        end
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            K_RESET: return "reset state";
            K_WRITE: return "write";
            K_READ: return "read";
            K_BAD_STOP: return "bad stop bit";
            K_UNKNOWN: return "unknown opcode";
            K_DISPLAY: return "display";
            K_BURST: return "burst";
            default: return "bad kind";
        endcase
    endfunction

    task automatic run_test(input int kind, input int op, input int addr,
                            input int data, input int expected);
        logic [7:0] burst_addr;
        int rnd;
        int i;
        case (kind)
            K_RESET: begin
                if (uart_txd !== 1'b1 || hex0 !== expected[6:0]) begin
                    $display("Error at %0t: after reset txd %b hex0 0x%02h, expected 1 and 0x%02h",
                             $time, uart_txd, hex0, expected[6:0]);
                    error_count++;
                end
            end
            K_WRITE: begin
                // Golden line against the protocol's ack byte
                if (expected[7:0] != `TAG_ACK_BYTE) begin
                    $display("Golden line expects ack 0x%02h, protocol uses 0x%02h",
                             expected[7:0], `TAG_ACK_BYTE);
                    error_count++;
                end
                do_write(op[7:0], addr[7:0], data[7:0]);
            end
            K_READ: begin
                if (expected[7:0] != shadow[addr[7:0]]) begin
                    $display("Golden line expects 0x%02h at 0x%02h but 0x%02h was written",
                             expected[7:0], addr[7:0], shadow[addr[7:0]]);
                    error_count++;
                end
                do_read(op[7:0], addr[7:0], expected[7:0]);
            end
            K_BAD_STOP: expect_silence(op[7:0], 1'b0);
            K_UNKNOWN: expect_silence(op[7:0], 1'b1);
            K_DISPLAY: begin
                if (addr[7:0] != `TAG_HEX_ADDR ||
                    expected[6:0] != SEG_TABLE[shadow[`TAG_HEX_ADDR][3:0]]) begin
                    $display("Golden display line disagrees with the written display word");
                    error_count++;
                end
                check_display(expected[6:0]);
            end
            K_BURST: begin
                // Random data while the refresher keeps competing for the bus
                for (i = 0; i < data; i++) begin
                    rnd = $random(seed);
                    burst_addr = 8'(addr + i);
                    // Random idle gap slides the request against the refresh timer
                    repeat (rnd[13:8]) @(negedge clk);
                    do_write(8'h57, burst_addr, rnd[7:0]);
                end
                for (i = 0; i < data; i++) begin
                    rnd = $random(seed);
                    burst_addr = 8'(addr + i);
                    repeat (rnd[5:0]) @(negedge clk);
                    do_read(8'h52, burst_addr, shadow[burst_addr]);
                end
            end
            default: begin
                $display("Golden file has an unsupported test kind %0d", kind);
                error_count++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        string line;
        int fd;
        int n;
        int kind;
        int op;
        int addr;
        int data;
        int expected;
        int test_no;
        int errs_before;
        int budget;
        clk = 1'b0;
        rst_n = 1'b0;
        uart_rxd = 1'b1;
        seed = 32'h7a81_8e1f;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        watch_cycles = 0;
        test_no = 0;
        for (int i = 0; i < `TAG_MEM_DEPTH; i++)
            shadow[i] = '0;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            error_count++;
        end else begin
            // Size the watchdog from the test list
            budget = 8 + `TAG_REFRESH_CYCLES;
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h", kind, op, addr, data, expected);
                if (n == 5) begin
                    budget += LINE_CYCLES;
                    if (kind == K_BURST)
                        budget += 2 * data * LINE_CYCLES;
                end
            end
            $fclose(fd);
            watch_cycles = budget;

            repeat (4) @(negedge clk);
            rst_n = 1'b1;

            fd = $fopen(GOLDEN_FILE, "r");
            while ($fgets(line, fd) != 0) begin
                // Comment and blank lines do not scan
                n = $sscanf(line, "%h %h %h %h %h", kind, op, addr, data, expected);
                if (n == 5) begin
                    test_no++;
                    errs_before = error_count;
                    run_test(kind, op, addr, data, expected);
                    if (error_count == errs_before) begin
                        pass_count++;
                        $display("Test %0d (%s) passed", test_no, kind_name(kind));
                    end else begin
                        fail_count++;
                        $display("Test %0d (%s) failed", test_no, kind_name(kind));
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests %0d, passed %0d, failed %0d, error lines %0d",
                 test_no, pass_count, fail_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule: tag_computer_tb

`default_nettype wire

/* all.f */
+incdir+logic
logic/tag_bus_pkg.sv
logic/tag_uart_pkg.sv
logic/mem_bus_if.sv
logic/word_ram.sv
logic/bus_arbiter.sv
logic/hex_refresh.sv
logic/uart_cmd_bridge.sv
logic/tag_computer.sv
tests/tag_computer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the tag_computer testbench with Verilator, run it, grade the log

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tag_computer_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -f all.f --top-module tag_computer_tb -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

/* tests/tag_golden.txt */
# kind opcode address data expected, all hex
# kinds: 0 reset, 1 write, 2 read, 3 bad stop bit, 4 unknown opcode, 5 display, 6 burst (data = count)
0 00 00 00 7f
2 52 10 00 00
1 57 10 a5 4b
2 52 10 00 a5
1 57 11 3c 4b
2 52 11 00 3c
3 57 00 00 00
2 52 10 00 a5
4 41 00 00 00
2 52 11 00 3c
1 57 f0 07 4b
5 00 f0 00 78
1 57 f0 3e 4b
5 00 f0 00 06
6 00 40 10 00
2 52 80 00 00
1 57 ff 5a 4b
2 52 ff 00 5a
